// ==== Bender.yml ====
package:
  name: btbFrontEnd

sources:
  - common/btbPkg.sv
  - rtl/btbEntryArray.sv
  - rtl/queuePointer.sv
  - btb/btb.sv
  - rtl/nextPcSelect.sv
  - rtl/btbFrontEnd.sv
  - target: test
    files:
      - tests/tbBtbFrontEnd.sv

# RTL top level: btbFrontEnd
# Testbench top level: tbBtbFrontEnd

// ==== btb/btb.sv ====
// Branch target buffer.
// Reads one entry per fetch slot and decodes hit and target a cycle later.
// Taken branch results are written directly or through a small update queue.
// After reset a sweep clears every entry before initDone rises.
`timescale 1ns/1ps
`default_nettype none

module btb #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2,
    parameter int queueSize = 4
) (
    input wire logic clk,
    input wire logic rstN,
    input btbPkg::pcT readPc,
    input btbPkg::brResultT brResult [issueWidth],
    output logic [fetchWidth-1:0] btbHit,
    output btbPkg::pcT btbTarget [fetchWidth],
    output logic [fetchWidth-1:0] btbIsCondBr,
    output logic initDone
);

    // Every write goes through one port.
    localparam int WRITE_NUM = 1;

    logic [WRITE_NUM-1:0] we;
    btbPkg::btbIndexT wa [WRITE_NUM];
    btbPkg::btbEntryT wv [WRITE_NUM];
    btbPkg::btbIndexT ra [fetchWidth];
    btbPkg::btbEntryT rv [fetchWidth];

    btbPkg::btbTagT tagReg [fetchWidth];
    btbPkg::btbIndexT sweepIdx;
    logic readLive;

    logic directWe;
    logic pushReq;
    logic pop;
    logic full;
    logic empty;
    logic [$clog2(queueSize)-1:0] headPtr;
    logic [$clog2(queueSize)-1:0] tailPtr;
    btbPkg::btbUpdateT directUpdate;
    btbPkg::btbUpdateT pushUpdate;
    btbPkg::btbUpdateT queue [queueSize];

    function automatic btbPkg::btbUpdateT makeUpdate(input btbPkg::brResultT br);
        btbPkg::btbUpdateT upd;
        upd.index = btbPkg::toBtbIndex(br.brAddr);
        upd.entry.valid = 1'b1;
        upd.entry.isCondBr = br.isCondBr;
        upd.entry.tag = btbPkg::toBtbTag(br.brAddr);
        upd.entry.target = btbPkg::toWordAddr(br.nextAddr);
        return upd;
    endfunction

    btbEntryArray #(
        .readNum(fetchWidth),
        .writeNum(WRITE_NUM)
    ) entryArray (
        .clk(clk),
        .we(we),
        .wa(wa),
        .wv(wv),
        .ra(ra),
        .rv(rv)
    );

    queuePointer #(
        .size(queueSize)
    ) updatePtr (
        .clk(clk),
        .rstN(rstN),
        .push(pushReq),
        .pop(pop),
        .full(full),
        .empty(empty),
        .headPtr(headPtr),
        .tailPtr(tailPtr)
    );

    // Read side: one index per consecutive slot, tags kept for next cycle's compare.
    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            ra[i] = btbPkg::toBtbIndex(readPc + btbPkg::pcT'(i * btbPkg::INSN_BYTES));
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < fetchWidth; i++) begin
            tagReg[i] <= btbPkg::toBtbTag(readPc + btbPkg::pcT'(i * btbPkg::INSN_BYTES));
        end
    end

    // The read issued in the last sweep cycle races the final clear, so it never hits.
    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            btbHit[i] = readLive && rv[i].valid && (rv[i].tag == tagReg[i]);
            btbTarget[i] = btbPkg::toPc(rv[i].target);
            btbIsCondBr[i] = rv[i].isCondBr;
        end
    end

    // Lane arbitration.
    // First taken lane writes directly, the next one is queued.
    always_comb begin
        directWe = 1'b0;
        pushReq = 1'b0;
        directUpdate = '0;
        pushUpdate = '0;
        if (initDone) begin
            for (int i = 0; i < issueWidth; i++) begin
                if (brResult[i].valid && brResult[i].taken) begin
                    if (!directWe) begin
                        directWe = 1'b1;
                        directUpdate = makeUpdate(brResult[i]);
                    end else if (!pushReq) begin
                        pushReq = 1'b1;
                        pushUpdate = makeUpdate(brResult[i]);
                    end
                end
            end
        end
    end

    // Drain only in cycles without a direct write.
    assign pop = initDone && !empty && !directWe;

    // Port 0 mux: sweep, then direct write, then queue head.
    always_comb begin
        we[0] = 1'b0;
        wa[0] = directUpdate.index;
        wv[0] = directUpdate.entry;
        if (!initDone) begin
            we[0] = 1'b1;
            wa[0] = sweepIdx;
            wv[0] = '0;
        end else if (directWe) begin
            we[0] = 1'b1;
        end else if (pop) begin
            we[0] = 1'b1;
            wa[0] = queue[headPtr].index;
            wv[0] = queue[headPtr].entry;
        end
    end

    // A full queue drops the update, leaving the entry stale.
    always_ff @(posedge clk) begin
        if (pushReq && !full) begin
            queue[tailPtr] <= pushUpdate;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sweepIdx <= '0;
            initDone <= 1'b0;
            readLive <= 1'b0;
        end else begin
            readLive <= initDone;
            if (!initDone) begin
                sweepIdx <= sweepIdx + 1'b1;
                if (sweepIdx == btbPkg::btbIndexT'(btbPkg::BTB_ENTRY_NUM - 1)) begin
                    initDone <= 1'b1;
                end
            end
        end
    end

    // Counts lost updates.
    queueDrop: cover property (@(posedge clk) disable iff (!rstN) initDone && pushReq && full);

endmodule

`default_nettype wire

// ==== btbFrontEnd.f ====
common/btbPkg.sv
rtl/btbEntryArray.sv
rtl/queuePointer.sv
btb/btb.sv
rtl/nextPcSelect.sv
rtl/btbFrontEnd.sv
tests/tbBtbFrontEnd.sv

// ==== common/btbPkg.sv ====
// Shared types for the branch target buffer and the next-PC stage.
// Holds the BTB geometry, entry and branch-result formats, and the
// helpers that split a PC into index, tag and word address.
`default_nettype none

package btbPkg;

    localparam int PC_WIDTH = 32;
    localparam int INSN_BYTES = 4;

    // Geometry of the entry array.
    localparam int BTB_ENTRY_NUM = 64;
    localparam int BTB_INDEX_WIDTH = $clog2(BTB_ENTRY_NUM);
    localparam int BTB_TAG_WIDTH = PC_WIDTH - 2 - BTB_INDEX_WIDTH;
    localparam int WORD_ADDR_WIDTH = PC_WIDTH - 2;

    typedef logic [PC_WIDTH-1:0] pcT;
    typedef logic [BTB_INDEX_WIDTH-1:0] btbIndexT;
    typedef logic [BTB_TAG_WIDTH-1:0] btbTagT;
    typedef logic [WORD_ADDR_WIDTH-1:0] wordAddrT;

    typedef struct packed {
        logic valid;
        logic isCondBr;
        btbTagT tag;
        wordAddrT target;
    } btbEntryT;

    // One resolved branch from the execute stage.
    typedef struct packed {
        logic valid;
        logic taken;
        logic isCondBr;
        pcT brAddr;
        pcT nextAddr;
    } brResultT;

    typedef struct packed {
        btbIndexT index;
        btbEntryT entry;
    } btbUpdateT;

    typedef struct packed {
        logic valid;
        pcT pc;
    } redirectT;

    typedef struct packed {
        logic valid;
        pcT pc;
        pcT predNextPc;
        logic taken;
        logic [2:0] takenLane;
        logic isCondBr;
    } fetchPredT;

    function automatic btbIndexT toBtbIndex(input pcT pc);
        return pc[BTB_INDEX_WIDTH+1:2];
    endfunction

    function automatic btbTagT toBtbTag(input pcT pc);
        return pc[PC_WIDTH-1:BTB_INDEX_WIDTH+2];
    endfunction

    // Targets are stored as word addresses; the low two bits are always zero.
    function automatic wordAddrT toWordAddr(input pcT pc);
        return pc[PC_WIDTH-1:2];
    endfunction

    function automatic pcT toPc(input wordAddrT addr);
        return {addr, 2'b00};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/btbEntryArray.sv ====
// BTB entry storage.
// Flop array with several write ports and registered read ports.
// On a same-cycle write conflict the higher port number wins.
`timescale 1ns/1ps
`default_nettype none

module btbEntryArray #(
    parameter int readNum = 2,
    parameter int writeNum = 1
) (
    input wire logic clk,
    input wire logic [writeNum-1:0] we,
    input btbPkg::btbIndexT wa [writeNum],
    input btbPkg::btbEntryT wv [writeNum],
    input btbPkg::btbIndexT ra [readNum],
    output btbPkg::btbEntryT rv [readNum]
);

    btbPkg::btbEntryT mem [btbPkg::BTB_ENTRY_NUM];

    // Ascending port order, so the last assignment from the highest port sticks.
    always_ff @(posedge clk) begin
        for (int i = 0; i < writeNum; i++) begin
            if (we[i]) begin
                mem[wa[i]] <= wv[i];
            end
        end
    end

    // Synchronous read.
    // Data reflects the array before this edge's writes.
    always_ff @(posedge clk) begin
        for (int i = 0; i < readNum; i++) begin
            rv[i] <= mem[ra[i]];
        end
    end

    // Writers sit in different lanes of the BTB.
    // Two of them hitting one index means the arbitration upstream broke.
    for (genvar i = 0; i < writeNum; i++) begin : gWriteCheck
        for (genvar j = i + 1; j < writeNum; j++) begin : gPair
            writeCollision: assert property (
                @(posedge clk) !(we[i] && we[j] && (wa[i] == wa[j]))
            ) else begin
                $error("btbEntryArray: ports %0d and %0d write index %0d", i, j, wa[i]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/btbFrontEnd.sv ====
// Fetch front end top.
// Couples the next-PC stage with the BTB that predicts its targets.
`timescale 1ns/1ps
`default_nettype none

module btbFrontEnd #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2,
    parameter int queueSize = 4,
    parameter btbPkg::pcT resetPc = '0
) (
    input wire logic clk,
    input wire logic rstN,
    input wire logic stall,
    input btbPkg::redirectT redirect,
    input btbPkg::brResultT brResult [issueWidth],
    output btbPkg::fetchPredT fetchOut,
    output logic initDone
);

    btbPkg::pcT readPc;
    logic [fetchWidth-1:0] btbHit;
    btbPkg::pcT btbTarget [fetchWidth];
    logic [fetchWidth-1:0] btbIsCondBr;

    nextPcSelect #(
        .fetchWidth(fetchWidth),
        .resetPc(resetPc)
    ) nextPc (
        .clk(clk),
        .rstN(rstN),
        .initDone(initDone),
        .stall(stall),
        .redirect(redirect),
        .btbHit(btbHit),
        .btbTarget(btbTarget),
        .btbIsCondBr(btbIsCondBr),
        .readPc(readPc),
        .fetchOut(fetchOut)
    );

    btb #(
        .fetchWidth(fetchWidth),
        .issueWidth(issueWidth),
        .queueSize(queueSize)
    ) targetBuffer (
        .clk(clk),
        .rstN(rstN),
        .readPc(readPc),
        .brResult(brResult),
        .btbHit(btbHit),
        .btbTarget(btbTarget),
        .btbIsCondBr(btbIsCondBr),
        .initDone(initDone)
    );

endmodule

`default_nettype wire

// ==== rtl/nextPcSelect.sv ====
// Next-PC stage.
// Holds the fetch PC and picks the next one from the BTB hits,
// a redirect, or the next sequential fetch group.
`timescale 1ns/1ps
`default_nettype none

module nextPcSelect #(
    parameter int fetchWidth = 2,
    parameter btbPkg::pcT resetPc = '0
) (
    input wire logic clk,
    input wire logic rstN,
    input wire logic initDone,
    input wire logic stall,
    input btbPkg::redirectT redirect,
    input wire logic [fetchWidth-1:0] btbHit,
    input btbPkg::pcT btbTarget [fetchWidth],
    input wire logic [fetchWidth-1:0] btbIsCondBr,
    output btbPkg::pcT readPc,
    output btbPkg::fetchPredT fetchOut
);

    btbPkg::pcT pcReg;
    btbPkg::pcT predNextPc;
    logic taken;
    logic [2:0] takenLane;
    logic takenIsCondBr;

    // Scan from the top lane down so the lowest hitting lane ends up selected.
    always_comb begin
        predNextPc = pcReg + btbPkg::pcT'(fetchWidth * btbPkg::INSN_BYTES);
        taken = 1'b0;
        takenLane = '0;
        takenIsCondBr = 1'b0;
        for (int i = fetchWidth - 1; i >= 0; i--) begin
            if (btbHit[i]) begin
                predNextPc = btbTarget[i];
                taken = 1'b1;
                takenLane = 3'(i);
                takenIsCondBr = btbIsCondBr[i];
            end
        end
    end

    // The PC the register takes next; the BTB reads it now so results line up.
    // Redirect beats stall.
    always_comb begin
        if (!initDone) begin
            readPc = resetPc;
        end else if (redirect.valid) begin
            readPc = redirect.pc;
        end else if (stall) begin
            readPc = pcReg;
        end else begin
            readPc = predNextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcReg <= resetPc;
        end else begin
            pcReg <= readPc;
        end
    end

    always_comb begin
        fetchOut.valid = initDone && !stall;
        fetchOut.pc = pcReg;
        fetchOut.predNextPc = predNextPc;
        fetchOut.taken = taken;
        fetchOut.takenLane = takenLane;
        fetchOut.isCondBr = takenIsCondBr;
    end

endmodule

`default_nettype wire

// ==== rtl/queuePointer.sv ====
// Circular queue pointer control.
// Head and tail wrap at the queue size; an occupancy count gives full and empty.
`timescale 1ns/1ps
`default_nettype none

module queuePointer #(
    parameter int size = 4
) (
    input wire logic clk,
    input wire logic rstN,
    input wire logic push,
    input wire logic pop,
    output logic full,
    output logic empty,
    output logic [$clog2(size)-1:0] headPtr,
    output logic [$clog2(size)-1:0] tailPtr
);

    localparam int PTR_WIDTH = $clog2(size);
    localparam int CNT_WIDTH = $clog2(size + 1);

    logic [CNT_WIDTH-1:0] count;
    logic doPush;
    logic doPop;

    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(size - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == CNT_WIDTH'(size));
    assign empty = (count == '0);

    // A push into a full queue is dropped.
    assign doPush = push && !full;
    assign doPop = pop && !empty;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (doPop) begin
                headPtr <= nextPtr(headPtr);
            end
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    popWhenEmpty: assert property (@(posedge clk) disable iff (!rstN) !(pop && empty))
        else $error("queuePointer: pop while empty");

endmodule

`default_nettype wire

// ==== tests/tbBtbFrontEnd.sv ====
// Testbench for the BTB fetch front end.
// Random branch results from an LFSR feed both the DUT and a reference model.
// Fetch group predictions are compared against the model after writes settle.
`timescale 1ns/1ps
`default_nettype none

module tbBtbFrontEnd;

    localparam int FETCH_WIDTH = 2;
    localparam int ISSUE_WIDTH = 2;
    localparam int QUEUE_SIZE = 4;
    localparam btbPkg::pcT RESET_PC = 32'h0000_0400;
    localparam int GROUP_BYTES = FETCH_WIDTH * btbPkg::INSN_BYTES;
    localparam int INIT_TIMEOUT = 4 * btbPkg::BTB_ENTRY_NUM;
    localparam int IDX_HI = btbPkg::BTB_INDEX_WIDTH + 1;

    typedef struct packed {
        btbPkg::btbTagT tag;
        btbPkg::pcT target;
        logic isCondBr;
    } modelEntryT;

    typedef struct packed {
        btbPkg::btbIndexT index;
        modelEntryT entry;
    } modelUpdateT;

    logic clk;
    logic rstN;
    logic stall;
    btbPkg::redirectT redirect;
    btbPkg::brResultT brResult [ISSUE_WIDTH];
    btbPkg::fetchPredT fetchOut;
    logic initDone;

    logic [31:0] lfsrState = 32'hf76d_e1d5;
    modelEntryT modelTable [int];
    modelUpdateT pendingUpdates [$];
    btbPkg::pcT writtenAddrs [$];
    btbPkg::pcT burstAddrs [$];

    btbFrontEnd #(
        .fetchWidth(FETCH_WIDTH),
        .issueWidth(ISSUE_WIDTH),
        .queueSize(QUEUE_SIZE),
        .resetPc(RESET_PC)
    ) dut0 (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .redirect(redirect),
        .brResult(brResult),
        .fetchOut(fetchOut),
        .initDone(initDone)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1, stepped once per bit.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        logic fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic btbPkg::pcT randPc();
        logic [31:0] bits;
        bits = randBits(30);
        return {bits[29:0], 2'b00};
    endfunction

    function automatic modelUpdateT toModelUpdate(input btbPkg::brResultT br);
        modelUpdateT upd;
        upd.index = br.brAddr[IDX_HI:2];
        upd.entry.tag = br.brAddr[btbPkg::PC_WIDTH-1:IDX_HI+1];
        upd.entry.target = {br.nextAddr[btbPkg::PC_WIDTH-1:2], 2'b00};
        upd.entry.isCondBr = br.isCondBr;
        return upd;
    endfunction

    // Expected group output. Lowest hitting lane wins.
    function automatic btbPkg::fetchPredT predict(input btbPkg::pcT pc, input logic validExp);
        btbPkg::fetchPredT exp;
        btbPkg::pcT slotPc;
        int idx;
        exp = '0;
        exp.valid = validExp;
        exp.pc = pc;
        exp.predNextPc = pc + btbPkg::pcT'(GROUP_BYTES);
        for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
            slotPc = pc + btbPkg::pcT'(i * btbPkg::INSN_BYTES);
            idx = int'(slotPc[IDX_HI:2]);
            if (modelTable.exists(idx) && modelTable[idx].tag == slotPc[31:IDX_HI+1]) begin
                exp.taken = 1'b1;
                exp.takenLane = 3'(i);
                exp.predNextPc = modelTable[idx].target;
                exp.isCondBr = modelTable[idx].isCondBr;
            end
        end
        return exp;
    endfunction

    task automatic stopOnFailure();
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        stopOnFailure();
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            reportMismatch(name, 32'(got), 32'(exp));
        end
    endtask

    task automatic checkPred(input btbPkg::fetchPredT got, input btbPkg::fetchPredT exp);
        if (got.valid !== exp.valid) begin
            reportMismatch("fetchOut.valid", 32'(got.valid), 32'(exp.valid));
        end
        if (got.pc !== exp.pc) begin
            reportMismatch("fetchOut.pc", got.pc, exp.pc);
        end
        if (got.predNextPc !== exp.predNextPc) begin
            reportMismatch("fetchOut.predNextPc", got.predNextPc, exp.predNextPc);
        end
        if (got.taken !== exp.taken) begin
            reportMismatch("fetchOut.taken", 32'(got.taken), 32'(exp.taken));
        end
        if (got.takenLane !== exp.takenLane) begin
            reportMismatch("fetchOut.takenLane", 32'(got.takenLane), 32'(exp.takenLane));
        end
        if (got.isCondBr !== exp.isCondBr) begin
            reportMismatch("fetchOut.isCondBr", 32'(got.isCondBr), 32'(exp.isCondBr));
        end
    endtask

    task automatic clearBranches();
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            brResult[i] = '0;
        end
    endtask

    task automatic setBranch(input int lane, input logic valid, input logic taken,
                             input logic isCondBr, input btbPkg::pcT addr,
                             input btbPkg::pcT next);
        brResult[lane].valid = valid;
        brResult[lane].taken = taken;
        brResult[lane].isCondBr = isCondBr;
        brResult[lane].brAddr = addr;
        brResult[lane].nextAddr = next;
    endtask

    // One clock of the model.
    // First taken lane writes, next one queues, queue drains when idle.
    task automatic applyModel();
        modelUpdateT direct;
        modelUpdateT pushed;
        logic haveDirect;
        logic havePush;
        logic wasFull;
        haveDirect = 1'b0;
        havePush = 1'b0;
        direct = '0;
        pushed = '0;
        wasFull = (pendingUpdates.size() == QUEUE_SIZE);
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (brResult[i].valid && brResult[i].taken) begin
                if (!haveDirect) begin
                    haveDirect = 1'b1;
                    direct = toModelUpdate(brResult[i]);
                end else if (!havePush) begin
                    havePush = 1'b1;
                    pushed = toModelUpdate(brResult[i]);
                end
            end
        end
        if (!haveDirect && pendingUpdates.size() > 0) begin
            haveDirect = 1'b1;
            direct = pendingUpdates.pop_front();
        end
        if (haveDirect) begin
            modelTable[int'(direct.index)] = direct.entry;
        end
        if (havePush && !wasFull) begin
            pendingUpdates.push_back(pushed);
        end
    endtask

    task automatic driveIdle(input logic st);
        redirect = '0;
        stall = st;
        clearBranches();
        applyModel();
    endtask

    task automatic driveRedirect(input btbPkg::pcT pc, input logic st);
        redirect.valid = 1'b1;
        redirect.pc = pc;
        stall = st;
        clearBranches();
        applyModel();
    endtask

    task automatic idleCycles(input int n, input logic st);
        repeat (n) begin
            @(negedge clk);
            driveIdle(st);
        end
    endtask

    task automatic lookup(input btbPkg::pcT pc);
        @(negedge clk);
        driveRedirect(pc, 1'b0);
        @(negedge clk);
        checkPred(fetchOut, predict(pc, 1'b1));
        checkBit("initDone", initDone, 1'b1);
        driveIdle(1'b0);
    endtask

    initial begin
        btbPkg::pcT addr;
        btbPkg::pcT prevAddr;
        btbPkg::pcT altPc;
        btbPkg::fetchPredT exp;
        logic found;
        int waited;
        int lane;
        rstN = 1'b0;
        stall = 1'b0;
        redirect = '0;
        clearBranches();
        prevAddr = RESET_PC;
        repeat (8) begin
            @(negedge clk);
            checkBit("initDone", initDone, 1'b0);
        end
        rstN = 1'b1;

        // Front end stays quiet during the clear sweep.
        waited = 0;
        @(negedge clk);
        while (initDone !== 1'b1) begin
            checkBit("fetchOut.valid", fetchOut.valid, 1'b0);
            if (waited >= INIT_TIMEOUT) begin
                $display("Timeout: initDone did not rise within %0d cycles", waited);
                stopOnFailure();
            end
            waited++;
            @(negedge clk);
        end

        // Empty BTB, so groups step sequentially.
        for (int k = 0; k < 8; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            checkPred(fetchOut, predict(RESET_PC + btbPkg::pcT'(k * GROUP_BYTES), 1'b1));
            checkBit("initDone", initDone, 1'b1);
            driveIdle(1'b0);
        end

        // Single taken branches while stalled.
        // Every third one follows the previous, so two lanes of one group hit.
        for (int n = 0; n < 16; n++) begin
            @(negedge clk);
            addr = (n % 3 == 2) ? prevAddr + btbPkg::pcT'(btbPkg::INSN_BYTES) : randPc();
            lane = int'(randBits(1));
            redirect = '0;
            stall = 1'b1;
            clearBranches();
            setBranch(lane, 1'b1, 1'b1, randBits(1) != 0, addr, randPc());
            applyModel();
            writtenAddrs.push_back(addr);
            prevAddr = addr;
        end
        idleCycles(6, 1'b1);
        foreach (writtenAddrs[i]) begin
            lookup(writtenAddrs[i]);
            lookup(writtenAddrs[i] - btbPkg::pcT'(btbPkg::INSN_BYTES));
        end

        // Both lanes taken back to back, which overflows the update queue.
        for (int n = 0; n < 6; n++) begin
            @(negedge clk);
            redirect = '0;
            stall = 1'b1;
            clearBranches();
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                addr = randPc();
                setBranch(l, 1'b1, 1'b1, randBits(1) != 0, addr, randPc());
                burstAddrs.push_back(addr);
            end
            applyModel();
        end
        idleCycles(QUEUE_SIZE + 4, 1'b1);
        foreach (burstAddrs[i]) begin
            lookup(burstAddrs[i]);
        end

        // Not-taken and invalid results must not write; the alias flips one tag bit.
        addr = writtenAddrs[0];
        @(negedge clk);
        redirect = '0;
        stall = 1'b0;
        clearBranches();
        setBranch(0, 1'b1, 1'b0, 1'b1, addr, randPc());
        setBranch(1, 1'b0, 1'b1, 1'b1, addr, randPc());
        applyModel();
        idleCycles(3, 1'b0);
        lookup(addr);
        lookup(addr ^ 32'h0100_0000);

        // Stall holds the group with valid low; redirect still lands.
        altPc = randPc();
        @(negedge clk);
        driveRedirect(altPc, 1'b1);
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            checkPred(fetchOut, predict(altPc, 1'b0));
            driveIdle(k < 3);
        end
        // Once the stall drops, the held group moves on to its prediction.
        exp = predict(altPc, 1'b1);
        @(negedge clk);
        checkPred(fetchOut, predict(exp.predNextPc, 1'b1));
        driveIdle(1'b0);

        // Redirect beats a BTB hit and a stall in the same cycle.
        found = 1'b0;
        foreach (burstAddrs[i]) begin
            exp = predict(burstAddrs[i], 1'b1);
            if (exp.taken) begin
                found = 1'b1;
                addr = burstAddrs[i];
            end
        end
        if (!found) begin
            $display("No written branch hits in the model, redirect check cannot run");
            stopOnFailure();
        end
        @(negedge clk);
        driveRedirect(addr, 1'b0);
        @(negedge clk);
        exp = predict(addr, 1'b1);
        checkPred(fetchOut, exp);
        altPc = exp.predNextPc ^ 32'h0000_1000;
        driveRedirect(altPc, 1'b1);
        @(negedge clk);
        checkPred(fetchOut, predict(altPc, 1'b0));
        exp = predict(altPc, 1'b1);
        driveIdle(1'b0);
        @(negedge clk);
        checkPred(fetchOut, predict(exp.predNextPc, 1'b1));
        driveIdle(1'b0);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
